// ==== debug_mem_bridge.f ====
rtl/debug_mem_bridge_pkg.sv
rtl/fetch_port.sv
rtl/data_port.sv
rtl/apb_arbiter.sv
rtl/debug_mem_bridge.sv
test/debug_mem_bridge_sva.sv
test/tb_debug_mem_bridge.sv

// ==== rtl/apb_arbiter.sv ====
/* Two-port arbiter and APB master toward the external debug module that grants
   the data port first and runs one setup and one access phase per transfer */
module apb_arbiter (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            i_fetch_req,
  input  debug_mem_bridge_pkg::apb_addr_t i_fetch_addr,
  input  logic                            i_data_req,
  input  debug_mem_bridge_pkg::apb_addr_t i_data_addr,
  input  logic                            i_data_write,
  input  debug_mem_bridge_pkg::word_t     i_data_wdata,
  output logic                            o_fetch_done,
  output logic                            o_data_done,
  output debug_mem_bridge_pkg::word_t     o_rdata,
  output debug_mem_bridge_pkg::apb_addr_t o_apb_paddr,
  output logic                            o_apb_psel,
  output logic                            o_apb_penable,
  output logic                            o_apb_pwrite,
  output debug_mem_bridge_pkg::word_t     o_apb_pwdata,
  input  logic                            i_apb_pready,
  input  debug_mem_bridge_pkg::word_t     i_apb_prdata
);

  debug_mem_bridge_pkg::arb_state_t state;
  debug_mem_bridge_pkg::apb_addr_t  paddr_q;
  debug_mem_bridge_pkg::word_t      pwdata_q;

  logic pwrite_q;
  logic grant_data;
  logic take_data;
  logic take_fetch;
  logic finish;

  // Grant decision as seen in idle only
  assign take_data  = (state == debug_mem_bridge_pkg::ARB_IDLE) && i_data_req;
  assign take_fetch = (state == debug_mem_bridge_pkg::ARB_IDLE) && !i_data_req &&
                      i_fetch_req;

  // ============================================================
  // Phase sequencing
  // ============================================================

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state      <= debug_mem_bridge_pkg::ARB_IDLE;
      grant_data <= 1'b0;
      pwrite_q   <= 1'b0;
    end
    else
    begin
      case (state)
        debug_mem_bridge_pkg::ARB_IDLE:
          if (take_data || take_fetch)
          begin
            state      <= debug_mem_bridge_pkg::ARB_SETUP;
            grant_data <= take_data;
            pwrite_q   <= take_data && i_data_write;
          end
        debug_mem_bridge_pkg::ARB_SETUP:
          state <= debug_mem_bridge_pkg::ARB_ACCESS;
        debug_mem_bridge_pkg::ARB_ACCESS:
          if (i_apb_pready)
            state <= debug_mem_bridge_pkg::ARB_IDLE;
        default:
          state <= debug_mem_bridge_pkg::ARB_IDLE;
      endcase
    end
  end

  // Granted address and write data held through wait states
  always_ff @(posedge clk)
  begin
    if (take_data)
    begin
      paddr_q  <= i_data_addr;
      pwdata_q <= i_data_wdata;
    end
    else if (take_fetch)
      paddr_q <= i_fetch_addr;
  end

  // ============================================================
  // APB outputs and completion
  // ============================================================

  assign o_apb_psel    = (state != debug_mem_bridge_pkg::ARB_IDLE);
  assign o_apb_penable = (state == debug_mem_bridge_pkg::ARB_ACCESS);
  assign o_apb_paddr   = paddr_q;
  assign o_apb_pwrite  = pwrite_q;
  assign o_apb_pwdata  = pwdata_q;

  assign finish = (state == debug_mem_bridge_pkg::ARB_ACCESS) && i_apb_pready;

  // Only the granted port sees done
  assign o_data_done  = finish && grant_data;
  assign o_fetch_done = finish && !grant_data;
  assign o_rdata      = i_apb_prdata;

endmodule

// ==== rtl/data_port.sv ====
/* Data access port with a local data RAM for registered reads and same-cycle
   writes that holds debug-area reads and writes as a request toward the arbiter */
module data_port (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic                             i_data_rd,
  input  logic                             i_data_wr,
  input  debug_mem_bridge_pkg::addr_t      i_data_addr,
  input  debug_mem_bridge_pkg::word_t      i_data_wdata,
  input  logic                             i_debug_mode,
  input  logic                             i_init_we,
  input  debug_mem_bridge_pkg::ram_index_t i_init_index,
  input  debug_mem_bridge_pkg::word_t      i_init_data,
  output logic                             o_data_rvalid,
  output debug_mem_bridge_pkg::word_t      o_data_rdata,
  output logic                             o_data_wready,
  output logic                             o_dbg_req,
  output debug_mem_bridge_pkg::apb_addr_t  o_dbg_addr,
  output logic                             o_dbg_write,
  output debug_mem_bridge_pkg::word_t      o_dbg_wdata,
  input  logic                             i_dbg_done,
  input  debug_mem_bridge_pkg::word_t      i_dbg_rdata
);

  debug_mem_bridge_pkg::word_t       dmem [debug_mem_bridge_pkg::RAM_DEPTH];
  debug_mem_bridge_pkg::word_t       ram_rdata;
  debug_mem_bridge_pkg::ram_index_t  data_index;
  debug_mem_bridge_pkg::port_state_t state;
  debug_mem_bridge_pkg::apb_addr_t   dbg_addr_q;
  debug_mem_bridge_pkg::word_t       dbg_wdata_q;

  logic dbg_write_q;
  logic is_debug;
  logic waiting;
  logic local_rd;
  logic local_wr;
  logic debug_start;
  logic local_rvalid;
  logic dbg_finish;

  // ============================================================
  // Routing decision
  // ============================================================

  assign data_index = i_data_addr[13:2];

  assign is_debug = i_debug_mode &&
                    (i_data_addr >= debug_mem_bridge_pkg::DEBUG_BASE) &&
                    (i_data_addr <= debug_mem_bridge_pkg::DEBUG_LAST);

  assign waiting  = (state == debug_mem_bridge_pkg::PORT_WAIT);
  assign local_rd = i_data_rd && !is_debug && !waiting;
  assign local_wr = i_data_wr && !is_debug && !waiting;

  assign debug_start = (i_data_rd || i_data_wr) && is_debug && !waiting;

  // ============================================================
  // Data RAM
  // ============================================================

  initial
  begin
    for (int i = 0; i < debug_mem_bridge_pkg::RAM_DEPTH; i++)
    begin
      dmem[i] = debug_mem_bridge_pkg::NOP_WORD;
    end
  end

  // Init and core writes share one write process
  always_ff @(posedge clk)
  begin
    if (i_init_we)
      dmem[i_init_index] <= i_init_data;
    if (local_wr)
      dmem[data_index] <= i_data_wdata;
  end

  always_ff @(posedge clk)
  begin
    if (local_rd)
      ram_rdata <= dmem[data_index];
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      local_rvalid <= 1'b0;
    else
      local_rvalid <= local_rd;
  end

  // ============================================================
  // Debug access holding
  // ============================================================

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state       <= debug_mem_bridge_pkg::PORT_IDLE;
      dbg_write_q <= 1'b0;
    end
    else
    begin
      case (state)
        debug_mem_bridge_pkg::PORT_IDLE:
          if (debug_start)
          begin
            state       <= debug_mem_bridge_pkg::PORT_WAIT;
            dbg_write_q <= i_data_wr;
          end
        debug_mem_bridge_pkg::PORT_WAIT:
          if (i_dbg_done)
            state <= debug_mem_bridge_pkg::PORT_IDLE;
        default:
          state <= debug_mem_bridge_pkg::PORT_IDLE;
      endcase
    end
  end

  // Address and write data for the APB transfer
  always_ff @(posedge clk)
  begin
    if (debug_start)
    begin
      dbg_addr_q  <= i_data_addr[12:0];
      dbg_wdata_q <= i_data_wdata;
    end
  end

  assign o_dbg_req   = waiting;
  assign o_dbg_addr  = dbg_addr_q;
  assign o_dbg_write = dbg_write_q;
  assign o_dbg_wdata = dbg_wdata_q;

  // ============================================================
  // Core responses
  // ============================================================

  assign dbg_finish = waiting && i_dbg_done;

  // Held write flag picks rvalid or wready on done
  assign o_data_rvalid = local_rvalid || (dbg_finish && !dbg_write_q);
  assign o_data_wready = local_wr || (dbg_finish && dbg_write_q);
  assign o_data_rdata  = waiting ? i_dbg_rdata : ram_rdata;

endmodule

// ==== rtl/debug_mem_bridge.sv ====
/* Memory side of a RISC-V core with instruction and data ports on local RAMs
   and debug-area accesses carried to the debug module over one APB master */
module debug_mem_bridge (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            i_fetch_req,
  input  debug_mem_bridge_pkg::addr_t     i_fetch_addr,
  input  logic                            i_debug_mode,
  output logic                            o_fetch_valid,
  output debug_mem_bridge_pkg::word_t     o_fetch_data,
  input  logic                            i_data_rd,
  input  logic                            i_data_wr,
  input  debug_mem_bridge_pkg::addr_t     i_data_addr,
  input  debug_mem_bridge_pkg::word_t     i_data_wdata,
  output logic                            o_data_rvalid,
  output debug_mem_bridge_pkg::word_t     o_data_rdata,
  output logic                            o_data_wready,
  input  logic                            i_init_wen,
  input  debug_mem_bridge_pkg::addr_t     i_init_addr,
  input  debug_mem_bridge_pkg::word_t     i_init_data,
  output logic                            o_unavailable,
  output debug_mem_bridge_pkg::apb_addr_t o_apb_paddr,
  output logic                            o_apb_psel,
  output logic                            o_apb_penable,
  output logic                            o_apb_pwrite,
  output debug_mem_bridge_pkg::word_t     o_apb_pwdata,
  input  logic                            i_apb_pready,
  input  debug_mem_bridge_pkg::word_t     i_apb_prdata
);

  debug_mem_bridge_pkg::ram_index_t init_index;
  debug_mem_bridge_pkg::apb_addr_t  fetch_dbg_addr;
  debug_mem_bridge_pkg::apb_addr_t  data_dbg_addr;
  debug_mem_bridge_pkg::word_t      data_dbg_wdata;
  debug_mem_bridge_pkg::word_t      dbg_rdata;

  logic init_we;
  logic fetch_dbg_req;
  logic fetch_dbg_done;
  logic data_dbg_req;
  logic data_dbg_write;
  logic data_dbg_done;

  // Init writes land only in the lower 16KB window
  assign init_we    = i_init_wen && (i_init_addr[15:14] == 2'b00);
  assign init_index = i_init_addr[13:2];

  // Core held off while memories are loaded
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      o_unavailable <= 1'b0;
    else
      o_unavailable <= i_init_wen;
  end

  fetch_port u_fetch_port (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_fetch_req   (i_fetch_req),
    .i_fetch_addr  (i_fetch_addr),
    .i_debug_mode  (i_debug_mode),
    .i_init_we     (init_we),
    .i_init_index  (init_index),
    .i_init_data   (i_init_data),
    .o_fetch_valid (o_fetch_valid),
    .o_fetch_data  (o_fetch_data),
    .o_dbg_req     (fetch_dbg_req),
    .o_dbg_addr    (fetch_dbg_addr),
    .i_dbg_done    (fetch_dbg_done),
    .i_dbg_rdata   (dbg_rdata)
  );

  data_port u_data_port (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_data_rd     (i_data_rd),
    .i_data_wr     (i_data_wr),
    .i_data_addr   (i_data_addr),
    .i_data_wdata  (i_data_wdata),
    .i_debug_mode  (i_debug_mode),
    .i_init_we     (init_we),
    .i_init_index  (init_index),
    .i_init_data   (i_init_data),
    .o_data_rvalid (o_data_rvalid),
    .o_data_rdata  (o_data_rdata),
    .o_data_wready (o_data_wready),
    .o_dbg_req     (data_dbg_req),
    .o_dbg_addr    (data_dbg_addr),
    .o_dbg_write   (data_dbg_write),
    .o_dbg_wdata   (data_dbg_wdata),
    .i_dbg_done    (data_dbg_done),
    .i_dbg_rdata   (dbg_rdata)
  );

  apb_arbiter u_apb_arbiter (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_fetch_req   (fetch_dbg_req),
    .i_fetch_addr  (fetch_dbg_addr),
    .i_data_req    (data_dbg_req),
    .i_data_addr   (data_dbg_addr),
    .i_data_write  (data_dbg_write),
    .i_data_wdata  (data_dbg_wdata),
    .o_fetch_done  (fetch_dbg_done),
    .o_data_done   (data_dbg_done),
    .o_rdata       (dbg_rdata),
    .o_apb_paddr   (o_apb_paddr),
    .o_apb_psel    (o_apb_psel),
    .o_apb_penable (o_apb_penable),
    .o_apb_pwrite  (o_apb_pwrite),
    .o_apb_pwdata  (o_apb_pwdata),
    .i_apb_pready  (i_apb_pready),
    .i_apb_prdata  (i_apb_prdata)
  );

endmodule

// ==== rtl/debug_mem_bridge_pkg.sv ====
/* Shared definitions for the debug memory bridge with its memory map,
   meaningful widths and the state encodings of the ports and arbiter */
package debug_mem_bridge_pkg;

  // ============================================================
  // Widths
  // ============================================================

  // Instruction or data word
  typedef logic [31:0] word_t;

  // Byte address as seen by the core
  typedef logic [31:0] addr_t;

  // Word index into one 4K-word RAM from core address bits 13:2
  typedef logic [11:0] ram_index_t;

  // Debug module APB address as the low 13 bits of a core address
  typedef logic [12:0] apb_addr_t;

  // ============================================================
  // Memory map
  // ============================================================

  localparam int RAM_DEPTH = 4096;

  // Debug area with both bounds inclusive
  localparam addr_t DEBUG_BASE = 32'h0000_0800;
  localparam addr_t DEBUG_LAST = 32'h0000_0FFF;

  // addi x0, x0, 0
  localparam word_t NOP_WORD = 32'h0000_0013;

  // ============================================================
  // State encodings
  // ============================================================

  // Request holding in fetch and data ports
  typedef enum logic {
    PORT_IDLE,
    PORT_WAIT
  } port_state_t;

  // External APB master phases
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_SETUP,
    ARB_ACCESS
  } arb_state_t;

endpackage

// ==== rtl/fetch_port.sv ====
/* Instruction fetch port with a local instruction RAM and registered read
   that holds debug-area fetches as a request toward the APB arbiter */
module fetch_port (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic                             i_fetch_req,
  input  debug_mem_bridge_pkg::addr_t      i_fetch_addr,
  input  logic                             i_debug_mode,
  input  logic                             i_init_we,
  input  debug_mem_bridge_pkg::ram_index_t i_init_index,
  input  debug_mem_bridge_pkg::word_t      i_init_data,
  output logic                             o_fetch_valid,
  output debug_mem_bridge_pkg::word_t      o_fetch_data,
  output logic                             o_dbg_req,
  output debug_mem_bridge_pkg::apb_addr_t  o_dbg_addr,
  input  logic                             i_dbg_done,
  input  debug_mem_bridge_pkg::word_t      i_dbg_rdata
);

  debug_mem_bridge_pkg::word_t       imem [debug_mem_bridge_pkg::RAM_DEPTH];
  debug_mem_bridge_pkg::word_t       ram_rdata;
  debug_mem_bridge_pkg::ram_index_t  fetch_index;
  debug_mem_bridge_pkg::port_state_t state;
  debug_mem_bridge_pkg::apb_addr_t   dbg_addr_q;

  logic is_debug;
  logic waiting;
  logic local_fetch;
  logic debug_start;
  logic local_valid;

  // ============================================================
  // Routing decision
  // ============================================================

  assign fetch_index = i_fetch_addr[13:2];

  assign is_debug = i_debug_mode &&
                    (i_fetch_addr >= debug_mem_bridge_pkg::DEBUG_BASE) &&
                    (i_fetch_addr <= debug_mem_bridge_pkg::DEBUG_LAST);

  assign waiting     = (state == debug_mem_bridge_pkg::PORT_WAIT);
  assign local_fetch = i_fetch_req && !is_debug && !waiting;
  assign debug_start = i_fetch_req && is_debug && !waiting;

  // ============================================================
  // Instruction RAM
  // ============================================================

  // Unwritten words fetch as NOP
  initial
  begin
    for (int i = 0; i < debug_mem_bridge_pkg::RAM_DEPTH; i++)
    begin
      imem[i] = debug_mem_bridge_pkg::NOP_WORD;
    end
  end

  // Only the init port writes here
  always_ff @(posedge clk)
  begin
    if (i_init_we)
      imem[i_init_index] <= i_init_data;
  end

  always_ff @(posedge clk)
  begin
    if (local_fetch)
      ram_rdata <= imem[fetch_index];
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      local_valid <= 1'b0;
    else
      local_valid <= local_fetch;
  end

  // ============================================================
  // Debug fetch holding
  // ============================================================

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      state <= debug_mem_bridge_pkg::PORT_IDLE;
    else
    begin
      case (state)
        debug_mem_bridge_pkg::PORT_IDLE:
          if (debug_start)
            state <= debug_mem_bridge_pkg::PORT_WAIT;
        debug_mem_bridge_pkg::PORT_WAIT:
          if (i_dbg_done)
            state <= debug_mem_bridge_pkg::PORT_IDLE;
        default:
          state <= debug_mem_bridge_pkg::PORT_IDLE;
      endcase
    end
  end

  // Held steady for the whole wait
  always_ff @(posedge clk)
  begin
    if (debug_start)
      dbg_addr_q <= i_fetch_addr[12:0];
  end

  assign o_dbg_req  = waiting;
  assign o_dbg_addr = dbg_addr_q;

  // APB read data goes straight through in the done cycle
  assign o_fetch_valid = local_valid || (waiting && i_dbg_done);
  assign o_fetch_data  = waiting ? i_dbg_rdata : ram_rdata;

endmodule

// ==== test/debug_mem_bridge_sva.sv ====
/* APB protocol, debug routing and reset checks bound into the
   debug memory bridge top level */
module debug_mem_bridge_sva (
  input logic                            clk,
  input logic                            reset_n,
  input logic                            i_debug_mode,
  input logic                            i_data_wr,
  input logic                            i_fetch_valid,
  input logic                            i_data_rvalid,
  input logic                            i_data_wready,
  input logic                            i_unavailable,
  input debug_mem_bridge_pkg::apb_addr_t i_paddr,
  input logic                            i_psel,
  input logic                            i_penable,
  input logic                            i_pwrite,
  input debug_mem_bridge_pkg::word_t     i_pwdata,
  input logic                            i_pready
);

  int error_count = 0;

  // ============================================================
  // APB phases
  // ============================================================

  // Access phase only after a setup phase
  penable_needs_psel: assert property (@(posedge clk) disable iff (!reset_n)
    i_penable |-> i_psel && $past(i_psel))
  else
  begin
    error_count++;
    $error("penable high without a preceding setup phase");
  end

  // Setup lasts one cycle
  setup_then_access: assert property (@(posedge clk) disable iff (!reset_n)
    i_psel && !i_penable |=> i_psel && i_penable)
  else
  begin
    error_count++;
    $error("setup phase not followed by an access phase");
  end

  // Wait states freeze the transfer
  // pwdata matters for writes only
  hold_while_waiting: assert property (@(posedge clk) disable iff (!reset_n)
    i_psel && i_penable && !i_pready |=>
      i_psel && i_penable && $stable(i_paddr) && $stable(i_pwrite) &&
      (!i_pwrite || $stable(i_pwdata)))
  else
  begin
    error_count++;
    $error("APB outputs changed while pready was low");
  end

  // ============================================================
  // Routing and reset
  // ============================================================

  psel_needs_debug_mode: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(i_psel) |-> i_debug_mode)
  else
  begin
    error_count++;
    $error("psel rose outside debug mode");
  end

  reset_clears_controls: assert property (@(posedge clk)
    $rose(reset_n) |-> !i_fetch_valid && !i_data_rvalid &&
      (!i_data_wready || i_data_wr) && !i_psel && !i_penable && !i_unavailable)
  else
  begin
    error_count++;
    $error("control outputs not low at the end of reset");
  end

endmodule

bind debug_mem_bridge debug_mem_bridge_sva u_sva (
  .clk           (clk),
  .reset_n       (reset_n),
  .i_debug_mode  (i_debug_mode),
  .i_data_wr     (i_data_wr),
  .i_fetch_valid (o_fetch_valid),
  .i_data_rvalid (o_data_rvalid),
  .i_data_wready (o_data_wready),
  .i_unavailable (o_unavailable),
  .i_paddr       (o_apb_paddr),
  .i_psel        (o_apb_psel),
  .i_penable     (o_apb_penable),
  .i_pwrite      (o_apb_pwrite),
  .i_pwdata      (o_apb_pwdata),
  .i_pready      (i_apb_pready)
);

// ==== test/tb_debug_mem_bridge.sv ====
/* Testbench for the debug memory bridge covering init loading and local and
   debug accesses against an APB slave model with random wait states */
module tb_debug_mem_bridge;

  localparam int          HALF_PERIOD    = 10;
  localparam int          IN_DELAY       = 2;
  localparam logic [15:0] LFSR_SEED      = 16'd7;
  localparam logic [31:0] RESP_MASK      = 32'hD0D0_0000;
  // Roughly 150 cycles of tests with at most 3 wait states per transfer
  localparam int          TIMEOUT_CYCLES = 4000;

  logic                            clk;
  logic                            reset_n;
  logic                            i_fetch_req;
  debug_mem_bridge_pkg::addr_t     i_fetch_addr;
  logic                            i_debug_mode;
  logic                            o_fetch_valid;
  debug_mem_bridge_pkg::word_t     o_fetch_data;
  logic                            i_data_rd;
  logic                            i_data_wr;
  debug_mem_bridge_pkg::addr_t     i_data_addr;
  debug_mem_bridge_pkg::word_t     i_data_wdata;
  logic                            o_data_rvalid;
  debug_mem_bridge_pkg::word_t     o_data_rdata;
  logic                            o_data_wready;
  logic                            i_init_wen;
  debug_mem_bridge_pkg::addr_t     i_init_addr;
  debug_mem_bridge_pkg::word_t     i_init_data;
  logic                            o_unavailable;
  debug_mem_bridge_pkg::apb_addr_t o_apb_paddr;
  logic                            o_apb_psel;
  logic                            o_apb_penable;
  logic                            o_apb_pwrite;
  debug_mem_bridge_pkg::word_t     o_apb_pwdata;
  logic                            i_apb_pready;
  debug_mem_bridge_pkg::word_t     i_apb_prdata;

  logic [15:0] lfsr_state = LFSR_SEED;
  int          wait_left = 0;
  int          cycle_count = 0;

  // Completed APB transfers in order
  debug_mem_bridge_pkg::apb_addr_t log_addr[$];
  logic                            log_write[$];
  debug_mem_bridge_pkg::word_t     log_wdata[$];

  debug_mem_bridge i_debug_mem_bridge (.*);

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // ============================================================
  // Helpers
  // ============================================================

  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  // 0 to 3 wait states with one LFSR step per bit
  function automatic int draw_wait_states();
    int n;
    n = 0;
    for (int i = 0; i < 2; i++)
      n = (n << 1) | lfsr_bit();
    return n;
  endfunction

  function automatic debug_mem_bridge_pkg::word_t slave_response(
    input debug_mem_bridge_pkg::apb_addr_t addr);
    return {19'b0, addr} ^ RESP_MASK;
  endfunction

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input debug_mem_bridge_pkg::word_t expected,
                            input debug_mem_bridge_pkg::word_t actual);
    assert (actual === expected)
    else
      stop_with_failure($sformatf("Fail at time %0t: %s expected %h, got %h",
                                  $time, name, expected, actual));
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond)
    else
      stop_with_failure(what);
  endtask

  task automatic tick();
    @(posedge clk);
    #IN_DELAY;
  endtask

  task automatic check_last_transfer(input debug_mem_bridge_pkg::addr_t addr,
                                     input logic write, input debug_mem_bridge_pkg::word_t wdata,
                                     input int prev_count);
    check_word("APB transfer count", prev_count + 1, log_addr.size());
    check_word("o_apb_paddr", addr[12:0], log_addr[$]);
    check_word("o_apb_pwrite", write, log_write[$]);
    if (write)
      check_word("o_apb_pwdata", wdata, log_wdata[$]);
  endtask

  // ============================================================
  // Core-side access tasks
  // ============================================================

  task automatic load_init_word(input debug_mem_bridge_pkg::addr_t addr,
                                input debug_mem_bridge_pkg::word_t data, input logic exp_unavail);
    i_init_wen  = 1'b1;
    i_init_addr = addr;
    i_init_data = data;
    @(negedge clk);
    check_word("o_unavailable", exp_unavail, o_unavailable);
    tick();
  endtask

  task automatic local_fetch(input debug_mem_bridge_pkg::addr_t addr,
                             input debug_mem_bridge_pkg::word_t expected);
    i_fetch_req  = 1'b1;
    i_fetch_addr = addr;
    tick();
    i_fetch_req = 1'b0;
    @(negedge clk);
    check_word("o_fetch_valid", 1'b1, o_fetch_valid);
    check_word("o_fetch_data", expected, o_fetch_data);
    tick();
  endtask

  task automatic local_write(input debug_mem_bridge_pkg::addr_t addr,
                             input debug_mem_bridge_pkg::word_t data);
    i_data_wr    = 1'b1;
    i_data_addr  = addr;
    i_data_wdata = data;
    @(negedge clk);
    check_word("o_data_wready", 1'b1, o_data_wready);
    tick();
    i_data_wr = 1'b0;
  endtask

  task automatic local_read(input debug_mem_bridge_pkg::addr_t addr,
                            input debug_mem_bridge_pkg::word_t expected);
    i_data_rd   = 1'b1;
    i_data_addr = addr;
    tick();
    i_data_rd = 1'b0;
    @(negedge clk);
    check_word("o_data_rvalid", 1'b1, o_data_rvalid);
    check_word("o_data_rdata", expected, o_data_rdata);
    tick();
  endtask

  task automatic debug_fetch(input debug_mem_bridge_pkg::addr_t addr);
    int count;
    count        = log_addr.size();
    i_fetch_req  = 1'b1;
    i_fetch_addr = addr;
    @(negedge clk);
    while (!o_fetch_valid)
      @(negedge clk);
    check_word("o_fetch_data", slave_response(addr[12:0]), o_fetch_data);
    check_last_transfer(addr, 1'b0, '0, count);
    tick();
    i_fetch_req = 1'b0;
  endtask

  task automatic debug_write(input debug_mem_bridge_pkg::addr_t addr,
                             input debug_mem_bridge_pkg::word_t data);
    int count;
    count        = log_addr.size();
    i_data_wr    = 1'b1;
    i_data_addr  = addr;
    i_data_wdata = data;
    @(negedge clk);
    while (!o_data_wready)
      @(negedge clk);
    // wready only once the APB write is on record
    check_last_transfer(addr, 1'b1, data, count);
    tick();
    i_data_wr = 1'b0;
  endtask

  task automatic debug_read(input debug_mem_bridge_pkg::addr_t addr);
    int count;
    count       = log_addr.size();
    i_data_rd   = 1'b1;
    i_data_addr = addr;
    @(negedge clk);
    while (!o_data_rvalid)
      @(negedge clk);
    check_word("o_data_rdata", slave_response(addr[12:0]), o_data_rdata);
    check_last_transfer(addr, 1'b0, '0, count);
    tick();
    i_data_rd = 1'b0;
  endtask

  // Fetch and data read into the debug area in the same cycle
  task automatic debug_both(input debug_mem_bridge_pkg::addr_t fetch_addr,
                            input debug_mem_bridge_pkg::addr_t data_addr);
    int   count;
    logic data_done;
    logic fetch_done;
    count        = log_addr.size();
    data_done    = 1'b0;
    fetch_done   = 1'b0;
    i_fetch_req  = 1'b1;
    i_fetch_addr = fetch_addr;
    i_data_rd    = 1'b1;
    i_data_addr  = data_addr;
    while (!(data_done && fetch_done))
    begin
      @(negedge clk);
      if (o_data_rvalid)
      begin
        check_true(!fetch_done, "Fetch completed before the waiting data access");
        check_word("o_data_rdata", slave_response(data_addr[12:0]), o_data_rdata);
        data_done = 1'b1;
      end
      if (o_fetch_valid)
      begin
        check_true(data_done, "Fetch completed before the waiting data access");
        check_word("o_fetch_data", slave_response(fetch_addr[12:0]), o_fetch_data);
        fetch_done = 1'b1;
      end
      tick();
      if (data_done)
        i_data_rd = 1'b0;
      if (fetch_done)
        i_fetch_req = 1'b0;
    end
    check_word("APB transfer count", count + 2, log_addr.size());
    check_word("first o_apb_paddr", data_addr[12:0], log_addr[count]);
    check_word("second o_apb_paddr", fetch_addr[12:0], log_addr[count + 1]);
  endtask

  // ============================================================
  // APB slave model and run monitors
  // ============================================================

  always @(posedge clk)
  begin
    #IN_DELAY;
    i_apb_pready = 1'b0;
    if (o_apb_psel && !o_apb_penable)
      wait_left = draw_wait_states();
    else if (o_apb_psel && o_apb_penable)
    begin
      if (wait_left == 0)
      begin
        i_apb_pready = 1'b1;
        i_apb_prdata = slave_response(o_apb_paddr);
        log_addr.push_back(o_apb_paddr);
        log_write.push_back(o_apb_pwrite);
        log_wdata.push_back(o_apb_pwdata);
      end
      else
        wait_left--;
    end
  end

  always @(negedge clk)
  begin
    if (i_debug_mem_bridge.u_sva.error_count != 0)
      stop_with_failure("A bound APB, routing or reset assertion failed");
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
      stop_with_failure("Timeout: the test sequence did not finish within the cycle limit");
  end

  // ============================================================
  // Test sequence
  // ============================================================

  initial
  begin
    reset_n      = 1'b0;
    i_fetch_req  = 1'b0;
    i_fetch_addr = '0;
    i_debug_mode = 1'b0;
    i_data_rd    = 1'b0;
    i_data_wr    = 1'b0;
    i_data_addr  = '0;
    i_data_wdata = '0;
    i_init_wen   = 1'b0;
    i_init_addr  = '0;
    i_init_data  = '0;
    i_apb_pready = 1'b0;
    i_apb_prdata = '0;
    repeat (5) @(posedge clk);
    #IN_DELAY;
    reset_n = 1'b1;
    tick();

    // The 0x4040 init write falls outside the window
    load_init_word(32'h0000_0040, 32'h0051_0093, 1'b0);
    load_init_word(32'h0000_0044, 32'h0020_8133, 1'b1);
    load_init_word(32'h0000_0080, 32'hCAFE_0001, 1'b1);
    load_init_word(32'h0000_4040, 32'hBAD0_BAD0, 1'b1);
    load_init_word(32'h0000_0840, 32'h7777_0840, 1'b1);
    i_init_wen = 1'b0;
    @(negedge clk);
    check_word("o_unavailable", 1'b1, o_unavailable);
    tick();
    @(negedge clk);
    check_word("o_unavailable", 1'b0, o_unavailable);
    tick();

    local_fetch(32'h0000_0040, 32'h0051_0093);
    local_fetch(32'h0000_0044, 32'h0020_8133);
    local_fetch(32'h0000_0100, debug_mem_bridge_pkg::NOP_WORD);

    local_write(32'h0000_0200, 32'h5A5A_1234);
    local_read(32'h0000_0200, 32'h5A5A_1234);
    local_read(32'h0000_0080, 32'hCAFE_0001);

    // Debug area from RAM while debug mode is low
    local_fetch(32'h0000_0840, 32'h7777_0840);
    local_read(32'h0000_0840, 32'h7777_0840);
    check_word("APB transfer count", 0, log_addr.size());

    // The write comes last so that it meets wait states
    i_debug_mode = 1'b1;
    debug_fetch(32'h0000_0804);
    debug_read(32'h0000_0FFC);
    debug_both(32'h0000_0A00, 32'h0000_0B10);
    debug_write(32'h0000_0800, 32'h1357_9BDF);
    i_debug_mode = 1'b0;
    tick();

    if (i_debug_mem_bridge.u_sva.error_count != 0)
      stop_with_failure("A bound APB, routing or reset assertion failed");
    else
    begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule
